//--- verilog/cl_firesim_defs.svh
`ifndef CL_FIRESIM_DEFS_SVH
`define CL_FIRESIM_DEFS_SVH

// ------------------------------
// bus and datapath widths
// ------------------------------
`define CL_OCL_ADDR_W 32            // ocl byte address
`define CL_DATA_W     32            // ocl data word
`define CL_TICK_W     8             // prescaler
`define CL_CNT_W      16            // event counter

// ------------------------------
// identity and status words
// ------------------------------
`define CL_SH_ID0     32'hF000_1D0F // vendor / device id
`define CL_SH_ID1     32'h1D51_FEDC // subsystem ids
`define CL_STATUS0    32'h0000_0FF0 // fixed status word
`define CL_VERSION    32'hEEEE_EE00 // build version

`endif

//--- verilog/cl_bus_pkg.sv
`include "cl_firesim_defs.svh"

package cl_bus_pkg;

  // ------------------------------
  // ocl axi-lite payload types
  // ------------------------------
  typedef logic [`CL_OCL_ADDR_W-1:0] ocl_addr_t;  // byte address
  typedef logic [`CL_DATA_W-1:0]     ocl_data_t;  // data word
  typedef logic [`CL_DATA_W/8-1:0]   ocl_strb_t;  // one enable per byte

  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,                          // normal access
    RESP_SLVERR = 2'b10                           // unmapped offset
  } ocl_resp_e;

  // ------------------------------
  // register map, byte offsets
  // ------------------------------
  typedef enum logic [7:0]
  {
    REG_ID0       = 8'h00,                        // ro, pci ids
    REG_ID1       = 8'h04,                        // ro, subsystem ids
    REG_STATUS0   = 8'h08,                        // ro, fixed status
    REG_VERSION   = 8'h0C,                        // ro, build version
    REG_CTRL      = 8'h10,                        // enable, oneshot, clear, load
    REG_TICK_VAL  = 8'h14,                        // prescaler terminal value
    REG_LOAD_VAL  = 8'h18,                        // counter preload
    REG_WATERMARK = 8'h1C,                        // compare threshold
    REG_COUNT     = 8'h20,                        // ro, {tick_cnt, cnt}
    REG_FLAGS     = 8'h24                         // ro, {ge_watermark, tick}
  } reg_ofs_e;

endpackage

//--- verilog/cl_cnt_pkg.sv
`include "cl_firesim_defs.svh"

package cl_cnt_pkg;

  // ------------------------------
  // counter block value types
  // ------------------------------
  typedef logic [`CL_TICK_W-1:0] tick_t;  // prescaler count
  typedef logic [`CL_CNT_W-1:0]  cnt_t;   // event count

  // controls handed from the register file to the counter block
  typedef struct packed
  {
    logic  enable;                        // count while set
    logic  oneshot;                       // saturate instead of wrap
    logic  clear;                         // one-cycle pulse
    logic  load;                          // one-cycle pulse
    tick_t tick_value;                    // prescaler terminal value
    cnt_t  load_value;                    // preload for load pulse
    cnt_t  watermark;                     // ge_watermark threshold
  } cnt_ctrl_t;

endpackage

//--- verilog/cl_ifs.sv
`timescale 1ns/100ps

// single-cycle register access between the ocl slave and the register file
interface reg_bus_if;

  import cl_bus_pkg::*;

  logic      wr;     // write strobe, one cycle
  logic      rd;     // read strobe, one cycle
  ocl_addr_t addr;   // byte address
  ocl_data_t wdata;
  ocl_strb_t wstrb;
  ocl_data_t rdata;  // comb answer, same cycle
  logic      err;    // unmapped offset

  modport master
  (
    output wr, rd, addr, wdata, wstrb,
    input  rdata, err
  );

  modport slave
  (
    input  wr, rd, addr, wdata, wstrb,
    output rdata, err
  );

endinterface

// counter controls out, counter state back
interface cnt_if;

  import cl_cnt_pkg::*;

  cnt_ctrl_t cfg;           // from the register file
  tick_t     tick_cnt;      // prescaler value
  cnt_t      cnt;           // event counter value
  logic      tick;          // prescaler wrap pulse
  logic      ge_watermark;  // cnt >= watermark

  modport ctrl (output cfg, input tick_cnt, cnt, tick, ge_watermark);
  modport core (input cfg, output tick_cnt, cnt, tick, ge_watermark);

endinterface

//--- verilog/cl_ocl_slave.sv
`timescale 1ns/100ps

module cl_ocl_slave
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n,
  input  cl_bus_pkg::ocl_addr_t awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  cl_bus_pkg::ocl_data_t wdata,
  input  cl_bus_pkg::ocl_strb_t wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output cl_bus_pkg::ocl_resp_e bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  cl_bus_pkg::ocl_addr_t araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output cl_bus_pkg::ocl_data_t rdata,
  output cl_bus_pkg::ocl_resp_e rresp,
  output logic                  rvalid,
  input  logic                  rready,
  reg_bus_if.master             bus
);

  import cl_bus_pkg::*;

  logic      wr_go;     // start a write next cycle
  logic      rd_go;     // start a read next cycle
  logic      wr_acc_q;  // aw/w accept cycle, also the register write strobe
  logic      rd_acc_q;  // ar accept cycle, also the register read strobe
  ocl_resp_e resp_c;

  // ------------------------------
  // accept decisions
  // ------------------------------
  // aw and w must arrive together, nothing while a b response is pending
  assign wr_go = awvalid & wvalid & ~bvalid & ~wr_acc_q;
  // writes win a tie so wr and rd strobes never overlap
  assign rd_go = arvalid & ~rvalid & ~rd_acc_q & ~wr_go;

  assign awready = wr_acc_q;
  assign wready  = wr_acc_q;  // same cycle as awready
  assign arready = rd_acc_q;

  // ------------------------------
  // register side strobes
  // ------------------------------
  assign bus.wr    = wr_acc_q;
  assign bus.rd    = rd_acc_q;
  assign bus.addr  = wr_acc_q ? awaddr : araddr;  // write address only during its strobe
  assign bus.wdata = wdata;                        // still held by the master
  assign bus.wstrb = wstrb;

  assign resp_c = bus.err ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      wr_acc_q <= 1'b0;
      rd_acc_q <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
    end
    else
    begin
      wr_acc_q <= wr_go;
      rd_acc_q <= rd_go;
      if (wr_acc_q)
        bvalid <= 1'b1;   // response the cycle after accept
      else if (bready)
        bvalid <= 1'b0;   // held until the host takes it
      if (rd_acc_q)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  // response payload, captured on the strobe and stable while valid
  always_ff @(posedge clk_main_a0)
  begin
    if (wr_acc_q)
      bresp <= resp_c;
    if (rd_acc_q)
    begin
      rdata <= bus.rdata;
      rresp <= resp_c;
    end
  end

endmodule

//--- verilog/cl_reg_file.sv
`timescale 1ns/100ps
`include "cl_firesim_defs.svh"

module cl_reg_file
(
  input  logic     clk_main_a0,
  input  logic     rst_main_n,
  reg_bus_if.slave bus,
  cnt_if.ctrl      cnt
);

  import cl_bus_pkg::*;
  import cl_cnt_pkg::*;

  reg_ofs_e  ofs;          // low address byte
  logic      ofs_hi_zero;  // nothing mapped above 0xff
  logic      hit;          // access lands on a defined register
  ocl_data_t rdata_c;
  cnt_ctrl_t ctrl_q;       // all host-written control state

  // per-byte update of a counter-width register
  function automatic cnt_t byte_merge(cnt_t cur, ocl_data_t d, ocl_strb_t s);
    cnt_t res;
    res = cur;
    for (int b = 0; b < `CL_CNT_W / 8; b++)
    begin
      if (s[b])
        res[b*8 +: 8] = d[b*8 +: 8];
    end
    return res;
  endfunction

  assign ofs         = reg_ofs_e'(bus.addr[7:0]);
  assign ofs_hi_zero = (bus.addr[`CL_OCL_ADDR_W-1:8] == '0);

  // ------------------------------
  // decode and read mux
  // ------------------------------
  always_comb
  begin
    rdata_c = '0;
    hit     = ofs_hi_zero;
    case (ofs)
      REG_ID0:       rdata_c = `CL_SH_ID0;
      REG_ID1:       rdata_c = `CL_SH_ID1;
      REG_STATUS0:   rdata_c = `CL_STATUS0;
      REG_VERSION:   rdata_c = `CL_VERSION;
      REG_CTRL:      rdata_c[1:0] = {ctrl_q.oneshot, ctrl_q.enable};  // pulses read as 0
      REG_TICK_VAL:  rdata_c[`CL_TICK_W-1:0] = ctrl_q.tick_value;
      REG_LOAD_VAL:  rdata_c[`CL_CNT_W-1:0] = ctrl_q.load_value;
      REG_WATERMARK: rdata_c[`CL_CNT_W-1:0] = ctrl_q.watermark;
      REG_COUNT:
      begin
        rdata_c[`CL_CNT_W-1:0]         = cnt.cnt;
        rdata_c[`CL_CNT_W +: `CL_TICK_W] = cnt.tick_cnt;  // prescaler in 23:16
      end
      REG_FLAGS:     rdata_c[1:0] = {cnt.ge_watermark, cnt.tick};
      default:       hit = 1'b0;  // hole in the map
    endcase
    if (!hit)
      rdata_c = '0;  // errored reads return zero
  end

  assign bus.rdata = rdata_c;
  assign bus.err   = ~hit;

  // ------------------------------
  // control register writes
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      ctrl_q <= '0;
    else
    begin
      ctrl_q.clear <= 1'b0;  // pulses last one cycle
      ctrl_q.load  <= 1'b0;
      if (bus.wr && hit)
      begin
        case (ofs)
          REG_CTRL:
          begin
            if (bus.wstrb[0])
            begin
              ctrl_q.enable  <= bus.wdata[0];
              ctrl_q.oneshot <= bus.wdata[1];
              ctrl_q.clear   <= bus.wdata[2];  // write-one pulse
              ctrl_q.load    <= bus.wdata[3];  // write-one pulse
            end
          end
          REG_TICK_VAL:
          begin
            if (bus.wstrb[0])
              ctrl_q.tick_value <= bus.wdata[`CL_TICK_W-1:0];
          end
          REG_LOAD_VAL:  ctrl_q.load_value <= byte_merge(ctrl_q.load_value, bus.wdata, bus.wstrb);
          REG_WATERMARK: ctrl_q.watermark  <= byte_merge(ctrl_q.watermark, bus.wdata, bus.wstrb);
          default:       ;  // read-only registers ignore writes
        endcase
      end
    end
  end

  assign cnt.cfg = ctrl_q;

endmodule

//--- verilog/cl_tick_counter.sv
`timescale 1ns/100ps

module cl_tick_counter
(
  input  logic clk_main_a0,
  input  logic rst_main_n,
  cnt_if.core  cnt
);

  import cl_cnt_pkg::*;

  cnt_ctrl_t cfg_q;       // controls, one cycle behind the registers
  tick_t     tick_cnt_q;  // prescaler
  cnt_t      cnt_q;       // event counter
  logic      tick_q;
  logic      ge_wm_q;
  logic      tick_hit;    // prescaler at its terminal value
  logic      cnt_sat;     // oneshot counter parked at all ones

  // >= so a lowered tick_value never strands the prescaler above it
  assign tick_hit = (tick_cnt_q >= cfg_q.tick_value);
  assign cnt_sat  = cfg_q.oneshot && (cnt_q == '1);

  // ------------------------------
  // prescaler and event counter
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cfg_q      <= '0;
      tick_cnt_q <= '0;
      cnt_q      <= '0;
      tick_q     <= 1'b0;
      ge_wm_q    <= 1'b0;
    end
    else
    begin
      cfg_q <= cnt.cfg;  // latch controls
      // prescaler: clear, hold when disabled, wrap at tick_value
      if (cfg_q.clear)
        tick_cnt_q <= '0;
      else if (cfg_q.enable)
        tick_cnt_q <= tick_hit ? '0 : tick_cnt_q + 1'b1;
      // event counter: clear, load, hold, step on tick
      if (cfg_q.clear)
        cnt_q <= '0;
      else if (cfg_q.load)
        cnt_q <= cfg_q.load_value;
      else if (cfg_q.enable && tick_hit && !cnt_sat)
        cnt_q <= cnt_q + 1'b1;  // wraps unless oneshot
      tick_q  <= cfg_q.enable & ~cfg_q.clear & tick_hit;  // once per tick_value+1 cycles
      ge_wm_q <= (cnt_q >= cfg_q.watermark);              // lags cnt by one
    end
  end

  assign cnt.tick_cnt     = tick_cnt_q;
  assign cnt.cnt          = cnt_q;
  assign cnt.tick         = tick_q;
  assign cnt.ge_watermark = ge_wm_q;

endmodule

//--- verilog/cl_firesim.sv
`timescale 1ns/100ps

module cl_firesim
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n,
  // ocl axi-lite from the shell
  input  cl_bus_pkg::ocl_addr_t awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  cl_bus_pkg::ocl_data_t wdata,
  input  cl_bus_pkg::ocl_strb_t wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output cl_bus_pkg::ocl_resp_e bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  cl_bus_pkg::ocl_addr_t araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output cl_bus_pkg::ocl_data_t rdata,
  output cl_bus_pkg::ocl_resp_e rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // counter status
  output logic                  tick,
  output logic                  cnt_ge_watermark
);

  reg_bus_if reg_bus ();  // slave -> register file
  cnt_if     cnt_bus ();  // register file -> counter block

  // ------------------------------
  // host register path
  // ------------------------------
  cl_ocl_slave ocl_slave_i
  (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .bus         (reg_bus.master)
  );

  cl_reg_file reg_file_i
  (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .bus         (reg_bus.slave),
    .cnt         (cnt_bus.ctrl)
  );

  cl_tick_counter tick_counter_i
  (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .cnt         (cnt_bus.core)
  );

  assign tick             = cnt_bus.tick;
  assign cnt_ge_watermark = cnt_bus.ge_watermark;

endmodule

//--- test/cl_firesim_properties.sv
`timescale 1ns/100ps

module cl_firesim_properties
(
  input logic                  clk_main_a0,
  input logic                  rst_main_n,
  input logic                  awready,
  input logic                  bvalid,
  input logic                  bready,
  input logic                  rvalid,
  input logic                  rready,
  input logic                  tick,
  input logic                  reg_wr,   // register write strobe
  input cl_cnt_pkg::cnt_ctrl_t cfg       // register file controls
);

  import cl_cnt_pkg::*;

  cnt_ctrl_t cfg_prev;   // controls one cycle ago
  logic [3:0]  quiet;    // cycles since the last control change
  logic [15:0] gap;      // cycles since the last tick
  logic        seen;     // a tick seen with settled controls
  logic        changed;

  assign changed = reg_wr || (cfg != cfg_prev);

  // ------------------------------
  // tick spacing tracker
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    cfg_prev <= cfg;
    if (!rst_main_n || changed)
    begin
      quiet <= '0;
      seen  <= 1'b0;
      gap   <= '0;
    end
    else
    begin
      if (quiet != 4'hF)
        quiet <= quiet + 4'd1;  // controls take a few cycles to reach tick
      if (tick)
      begin
        gap  <= 16'd1;
        seen <= (quiet >= 4'd4);
      end
      else
        gap <= gap + 16'd1;
    end
  end

  // ------------------------------
  // handshake rules
  // ------------------------------
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    bvalid |-> !awready)
    else $error("write accepted while a write response is pending");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    tick && seen && !changed |-> gap == {8'd0, cfg.tick_value} + 16'd1)
    else $error("tick spacing differs from tick_value plus one");

endmodule

bind cl_firesim cl_firesim_properties props_i
(
  .clk_main_a0 (clk_main_a0),
  .rst_main_n  (rst_main_n),
  .awready     (awready),
  .bvalid      (bvalid),
  .bready      (bready),
  .rvalid      (rvalid),
  .rready      (rready),
  .tick        (tick),
  .reg_wr      (reg_bus.wr),
  .cfg         (cnt_bus.cfg)
);

//--- test/tb_cl_firesim.sv
`timescale 1ns/100ps
`include "cl_firesim_defs.svh"

module tb_cl_firesim;

  localparam int CLK_PERIOD   = 100;
  localparam int TEST_BUDGET  = 400;   // cycles allowed per test
  localparam int NUM_TESTS    = 6;
  localparam int MARGIN       = 200;
  localparam int HS_LIMIT     = 50;    // cycles per handshake wait

  logic clk_main_a0;
  logic rst_main_n;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic tick, cnt_ge_watermark;

  integer seed = 55157;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err0;
  int     cycle_no = 0;
  int     read_stamp;          // cycle of the last read response
  logic [31:0] rd_val, c1, c2;
  logic [1:0]  resp;
  int     k, diff;

  cl_firesim cl_firesim_i (.*);

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD/2) clk_main_a0 = ~clk_main_a0;
  end

  always @(posedge clk_main_a0)
    cycle_no <= cycle_no + 1;

  // watchdog
  initial
  begin
    #((NUM_TESTS * TEST_BUDGET + MARGIN) * CLK_PERIOD);
    $display("watchdog: simulation ran past its cycle budget");
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------
  // check helpers
  // ------------------------------
  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_near(string name, int exp, int act);
    assert (act >= exp - 1 && act <= exp + 1)
    else
    begin
      $display("[FAIL] %s expected %0d (+/-1) actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_stall(string what);
    $display("handshake stalled waiting for %s", what);
    errors++;
  endtask

  task automatic start_test();
    test_err0 = errors;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors != test_err0)
      tests_failed++;
    $display("test %s: %s", name, (errors == test_err0) ? "ok" : "errors");
  endtask

  // ------------------------------
  // ocl bus tasks
  // ------------------------------
  task automatic take_bresp(output logic [1:0] r);
    int n;
    repeat ($unsigned($random(seed)) % 4) @(negedge clk_main_a0);  // late bready
    n = 0;
    while (!bvalid && n < HS_LIMIT)
    begin
      @(negedge clk_main_a0);
      n++;
    end
    if (!bvalid)
      report_stall("bvalid");
    r = bresp;
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic ocl_write(logic [31:0] a, logic [31:0] d, logic [3:0] s,
                           output logic [1:0] r);
    int n;
    @(negedge clk_main_a0);
    awaddr = a;
    wdata = d;
    wstrb = s;
    awvalid = 1'b1;
    wvalid = 1'b1;
    n = 0;
    do
    begin
      @(negedge clk_main_a0);
      n++;
    end
    while (!awready && n < HS_LIMIT);
    if (!awready)
      report_stall("awready");
    else
      check("wready with awready", 32'd1, {31'd0, wready});  // aw and w taken together
    @(negedge clk_main_a0);  // hold address past the write edge
    awvalid = 1'b0;
    wvalid = 1'b0;
    take_bresp(r);
  endtask

  task automatic ocl_read(logic [31:0] a, output logic [31:0] d, output logic [1:0] r);
    int n;
    @(negedge clk_main_a0);
    araddr = a;
    arvalid = 1'b1;
    n = 0;
    do
    begin
      @(negedge clk_main_a0);
      n++;
    end
    while (!arready && n < HS_LIMIT);
    if (!arready)
      report_stall("arready");
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    read_stamp = cycle_no;  // rdata captured on the edge just passed
    repeat ($unsigned($random(seed)) % 4) @(negedge clk_main_a0);
    if (!rvalid)
      report_stall("rvalid");
    d = rdata;
    r = rresp;
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  task automatic wr(logic [31:0] a, logic [31:0] d);
    logic [1:0] r;
    ocl_write(a, d, 4'hF, r);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    rst_main_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (3) @(negedge clk_main_a0);
    rst_main_n = 1'b1;

    start_test();  // identity words
    ocl_read(32'h00, rd_val, resp);
    check("id0", `CL_SH_ID0, rd_val);
    check("id0 resp", 32'd0, {30'd0, resp});
    ocl_read(32'h04, rd_val, resp);
    check("id1", `CL_SH_ID1, rd_val);
    ocl_read(32'h08, rd_val, resp);
    check("status0", `CL_STATUS0, rd_val);
    ocl_read(32'h0C, rd_val, resp);
    check("version", `CL_VERSION, rd_val);
    check("version resp", 32'd0, {30'd0, resp});
    end_test("identity");

    start_test();  // masking and byte enables
    wr(32'h14, 32'hFFFF_FFA5);
    ocl_read(32'h14, rd_val, resp);
    check("tick_val mask", 32'h0000_00A5, rd_val);
    wr(32'h18, 32'h1234_5678);
    ocl_read(32'h18, rd_val, resp);
    check("load_val mask", 32'h0000_5678, rd_val);
    ocl_write(32'h18, 32'h0000_9900, 4'b0010, resp);
    ocl_read(32'h18, rd_val, resp);
    check("load_val strb", 32'h0000_9978, rd_val);
    wr(32'h1C, 32'hFFFF_ABCD);
    ocl_read(32'h1C, rd_val, resp);
    check("watermark mask", 32'h0000_ABCD, rd_val);
    wr(32'h10, 32'h0000_000C);
    ocl_read(32'h10, rd_val, resp);
    check("ctrl pulses", 32'h0, rd_val);
    end_test("registers");

    start_test();  // prescaler rate with N = 3
    wr(32'h14, 32'd3);
    wr(32'h10, 32'h1);
    repeat (20) @(negedge clk_main_a0);
    ocl_read(32'h20, c1, resp);
    k = read_stamp;
    repeat (40) @(negedge clk_main_a0);
    ocl_read(32'h20, c2, resp);
    k = read_stamp - k;
    diff = int'(c2[15:0] - c1[15:0]);
    check_near("count rate", k / 4, diff);
    check("tick_cnt range", 32'd1, {31'd0, c2[23:16] <= 8'd3});
    wr(32'h10, 32'h0);
    end_test("prescaler");

    start_test();  // load then clear
    wr(32'h18, 32'h0321);
    wr(32'h10, 32'h8);
    repeat (3) @(negedge clk_main_a0);
    ocl_read(32'h20, rd_val, resp);
    check("load", 32'h0321, {16'd0, rd_val[15:0]});
    wr(32'h10, 32'h4);
    repeat (3) @(negedge clk_main_a0);
    ocl_read(32'h20, rd_val, resp);
    check("clear", 32'h0, rd_val);
    end_test("load_clear");

    start_test();  // oneshot, wrap and watermark
    wr(32'h14, 32'd1);
    wr(32'h1C, 32'h8000);
    wr(32'h18, 32'hFFFE);
    wr(32'h10, 32'h0A);       // oneshot + load
    wr(32'h10, 32'h03);       // enable + oneshot
    repeat (20) @(negedge clk_main_a0);
    ocl_read(32'h20, rd_val, resp);
    check("oneshot sat", 32'hFFFF, {16'd0, rd_val[15:0]});
    ocl_read(32'h24, rd_val, resp);
    check("flags ge", 32'd1, {31'd0, rd_val[1]});
    check("ge pin", 32'd1, {31'd0, cnt_ge_watermark});
    wr(32'h10, 32'h08);       // reload, disabled
    wr(32'h10, 32'h01);       // count and wrap
    repeat (20) @(negedge clk_main_a0);
    wr(32'h10, 32'h00);       // freeze
    repeat (4) @(negedge clk_main_a0);
    ocl_read(32'h20, c1, resp);
    check("wrapped", 32'd1, {31'd0, c1[15:0] < 16'hFFFE});
    ocl_read(32'h24, rd_val, resp);
    check("flags ge wrap", {31'd0, c1[15:0] >= 16'h8000}, {31'd0, rd_val[1]});
    check("ge pin wrap", {31'd0, c1[15:0] >= 16'h8000}, {31'd0, cnt_ge_watermark});
    end_test("oneshot_wrap");

    start_test();  // unmapped offset and back-pressure
    ocl_write(32'h40, 32'h1, 4'hF, resp);
    check("wr slverr", 32'd2, {30'd0, resp});
    ocl_read(32'h40, rd_val, resp);
    check("rd slverr", 32'd2, {30'd0, resp});
    check("rd slverr data", 32'h0, rd_val);
    @(negedge clk_main_a0);
    awaddr = 32'h1C;
    wdata = 32'h1111;
    wstrb = 4'hF;
    awvalid = 1'b1;
    wvalid = 1'b1;
    while (!awready)
      @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    wdata = 32'h2222;         // second write queued behind the response
    repeat (6)
    begin
      @(negedge clk_main_a0);
      check("awready held off", 32'd0, {31'd0, awready});
    end
    take_bresp(resp);
    while (!awready)
      @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid = 1'b0;
    take_bresp(resp);
    ocl_read(32'h1C, rd_val, resp);
    check("second write", 32'h2222, rd_val);
    end_test("errors_backpressure");

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/cl_bus_pkg.sv
verilog/cl_cnt_pkg.sv
verilog/cl_ifs.sv
verilog/cl_ocl_slave.sv
verilog/cl_reg_file.sv
verilog/cl_tick_counter.sv
verilog/cl_firesim.sv
test/cl_firesim_properties.sv
test/tb_cl_firesim.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cl_firesim testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f \
  --top-module tb_cl_firesim -o sim_tb || exit 1

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "^TB PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
